//--- src.f
+incdir+include
src/barrel_pkg.sv
src/thread_pc_if.sv
src/delay_line.sv
src/branch_condition.sv
src/thread_sequencer.sv
src/thread_pc_store.sv
src/pc_unit.sv
src/barrel_controller.sv
testbench/tb_clock.sv
testbench/barrel_controller_sva.sv
testbench/tb_barrel_controller.sv

//--- run.sh
#!/bin/sh
# build and run the barrel controller testbench, exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_barrel_controller \
    -f src.f \
    && ./obj_dir/Vtb_barrel_controller +verilator+error+limit+100 \
    || exit 1

exit 0

//--- testbench/tb_barrel_controller.sv
`timescale 1ns/1ps

module tb_barrel_controller;
    import barrel_pkg::*;

    localparam int TIMEOUT_CYCLES = 600;  // all phases plus margin

    logic        clock;
    logic        rst_n;
    opcode_t     op;
    word_t       a;
    pc_t         d;
    logic        io_ready;
    pc_t         pc;
    thread_t     thread;
    logic [31:0] rng_state;
    int          cycle_count = 0;
    logic        check_failed;

    tb_clock clock_gen (.clock (clock));

    barrel_controller barrel_controller_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .op       (op),
        .a        (a),
        .d        (d),
        .io_ready (io_ready),
        .pc       (pc),
        .thread   (thread)
    );

    assign check_failed = barrel_controller_inst.sva_inst.assertion_failed;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // fold the branch codes down onto ordinary ones
    function automatic opcode_t non_branch_op(logic [3:0] code);
        if (code >= 4'd8 && code <= 4'd12) begin
            return opcode_t'(code - 4'd8);
        end
        return opcode_t'(code);
    endfunction

    task automatic apply_cycle(opcode_t op_in, word_t a_in, pc_t d_in, logic ready_in);
        op       = op_in;
        a        = a_in;
        d        = d_in;
        io_ready = ready_in;
        @(posedge clock);
        #1;  // next drive point
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        logic [31:0] r;
        opcode_t     branch_ops [5];
        word_t       acc;
        branch_ops = '{op_jmp, op_jze, op_jnz, op_jpo, op_jne};
        rng_state  = 32'hc3ca_2466;
        rst_n      = 1'b0;
        op         = opcode_t'(0);
        a          = '0;
        d          = '0;
        io_ready   = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < 64; i++) begin  // plain sequential fetch
            r = next_random();
            apply_cycle(non_branch_op(r[3:0]), r[31:16], pc_t'(r[13:4]), 1'b1);
        end
        for (int i = 0; i < 64; i++) begin  // stalls mixed in
            r = next_random();
            apply_cycle(non_branch_op(r[3:0]), r[31:16], pc_t'(r[13:4]), r[20]);
        end
        for (int i = 0; i < 80; i++) begin  // every branch against zero, plus, minus
            r = next_random();
            case ((i / 5) % 3)
                0:       acc = '0;
                1:       acc = {1'b0, r[30:16]} | word_t'(1);
                default: acc = {1'b1, r[30:16]};
            endcase
            apply_cycle(branch_ops[i % 5], acc, pc_t'(r[9:0]), 1'b1);
        end
        for (int i = 0; i < 200; i++) begin
            r = next_random();
            apply_cycle(opcode_t'(r[3:0]), r[31:16], pc_t'(r[13:4]), r[14]);
        end

        // jumps and stalls still in flight when reset hits
        apply_cycle(op_jmp, '0, pc_t'(10'h2a5), 1'b0);
        apply_cycle(op_jmp, '0, pc_t'(10'h15a), 1'b0);
        rst_n = 1'b0;
        apply_cycle(op_jmp, '0, pc_t'(10'h3ff), 1'b0);  // single reset edge
        rst_n = 1'b1;
        for (int i = 0; i < 24; i++) begin
            r = next_random();
            apply_cycle(non_branch_op(r[3:0]), r[31:16], pc_t'(r[13:4]), 1'b1);
        end
        repeat (3) apply_cycle(opcode_t'(0), '0, '0, 1'b1);  // drain the pipeline

        if (check_failed) begin
            $display("RESULT: FAIL");
            $fatal(1, "assertion failures were reported during the run");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // failure watch and timeout
    // ------------------------------------------------------------
    initial begin
        wait (check_failed === 1'b1);
        $display("RESULT: FAIL");
        $fatal(1, "an assertion in barrel_controller_sva failed");
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("RESULT: FAIL");
            $fatal(1, "timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

endmodule

//--- testbench/barrel_controller_sva.sv
`timescale 1ns/1ps
`include "barrel_macros.svh"

module barrel_controller_sva (
    input logic                clock,
    input logic                rst_n,
    input barrel_pkg::opcode_t op,
    input barrel_pkg::word_t   a,
    input barrel_pkg::pc_t     d,
    input logic                io_ready,
    input barrel_pkg::pc_t     pc,
    input barrel_pkg::thread_t thread
);
    import barrel_pkg::*;

    logic    assertion_failed = 1'b0;  // watched by the testbench

    thread_t model_thread;
    pc_t     model_next_pc [`BC_THREAD_COUNT];
    // input history where stage 2 acts on pc now
    logic    valid_h1, valid_h2;
    opcode_t op_h1, op_h2;
    word_t   a_h1, a_h2;
    pc_t     d_h1, d_h2;
    logic    ready_h1, ready_h2;

    logic    exp_jump;
    logic    exp_ready;
    pc_t     stored_pc;
    pc_t     exp_pc;

    // jump conditions on the accumulator
    function automatic logic branch_taken(opcode_t code, word_t acc);
        logic negative;
        negative = acc[`BC_A_WORD_WIDTH-1];
        if (code == op_jmp) return 1'b1;
        if (code == op_jze) return acc == '0;
        if (code == op_jnz) return acc != '0;
        if (code == op_jpo) return !negative;
        if (code == op_jne) return negative;
        return 1'b0;  // any other code falls through
    endfunction

    // ------------------------------------------------------------
    // reference model of the active thread
    // ------------------------------------------------------------
    always_comb begin
        exp_jump  = valid_h2 && branch_taken(op_h2, a_h2);
        exp_ready = !valid_h2 || ready_h2;  // nothing pending means ready
        stored_pc = model_next_pc[model_thread];
        if (exp_jump) begin
            exp_pc = d_h2;
        end else if (exp_ready) begin
            exp_pc = stored_pc;
        end else begin
            exp_pc = stored_pc - pc_t'(1);  // refetch
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            model_thread <= '0;
            for (int i = 0; i < `BC_THREAD_COUNT; i++) begin
                model_next_pc[i] <= '0;
            end
            valid_h1 <= 1'b0;
            valid_h2 <= 1'b0;
        end else begin
            model_next_pc[model_thread] <= exp_pc + pc_t'(exp_ready);
            model_thread <= thread_t'((int'(model_thread) + 1) % `BC_THREAD_COUNT);
            valid_h1 <= 1'b1;
            valid_h2 <= valid_h1;
        end
        op_h1    <= op;
        a_h1     <= a;
        d_h1     <= d;
        ready_h1 <= io_ready;
        op_h2    <= op_h1;
        a_h2     <= a_h1;
        d_h2     <= d_h1;
        ready_h2 <= ready_h1;
    end

    // ------------------------------------------------------------
    // checks against the model
    // ------------------------------------------------------------
    thread_rotation: assert property (@(posedge clock) disable iff (!rst_n)
        thread == model_thread)
        else begin
            $error("ERROR %0t: thread is %0d, expected %0d", $time,
                $sampled(thread), $sampled(model_thread));
            assertion_failed = 1'b1;
        end

    sequential_fetch: assert property (@(posedge clock) disable iff (!rst_n)
        (!exp_jump && exp_ready) |-> (pc == stored_pc))
        else begin
            $error("ERROR %0t: pc is %0h, expected next-pc %0h", $time,
                $sampled(pc), $sampled(stored_pc));
            assertion_failed = 1'b1;
        end

    stall_replay: assert property (@(posedge clock) disable iff (!rst_n)
        (!exp_jump && !exp_ready) |-> (pc == stored_pc - pc_t'(1)))
        else begin
            $error("ERROR %0t: pc is %0h on a stall, expected %0h", $time,
                $sampled(pc), $sampled(exp_pc));
            assertion_failed = 1'b1;
        end

    branch_target: assert property (@(posedge clock) disable iff (!rst_n)
        exp_jump |-> (pc == d_h2))
        else begin
            $error("ERROR %0t: pc is %0h on a taken jump, expected %0h", $time,
                $sampled(pc), $sampled(d_h2));
            assertion_failed = 1'b1;
        end

endmodule

bind barrel_controller barrel_controller_sva sva_inst (
    .clock    (clock),
    .rst_n    (rst_n),
    .op       (op),
    .a        (a),
    .d        (d),
    .io_ready (io_ready),
    .pc       (pc),
    .thread   (thread)
);

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock = ~clock;  // half period per phase
        end
    end

endmodule

//--- src/barrel_controller.sv
`timescale 1ns/1ps

module barrel_controller (
    input  logic                clock,
    input  logic                rst_n,
    input  barrel_pkg::opcode_t op,
    input  barrel_pkg::word_t   a,
    input  barrel_pkg::pc_t     d,
    input  logic                io_ready,
    output barrel_pkg::pc_t     pc,
    output barrel_pkg::thread_t thread
);

    // ------------------------------------------------------------
    // thread addresses and next-PC traffic
    // ------------------------------------------------------------
    thread_pc_if threads ();

    thread_sequencer thread_sequencer_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .threads (threads.sequencer),
        .thread  (thread)
    );

    thread_pc_store thread_pc_store_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .threads (threads.store)
    );

    // branch and stall handling for the active thread
    pc_unit pc_unit_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .op       (op),
        .a        (a),
        .d        (d),
        .io_ready (io_ready),
        .threads  (threads.pc_unit),
        .pc       (pc)
    );

endmodule

//--- src/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic                clock,
    input  logic                rst_n,
    input  barrel_pkg::opcode_t op,
    input  barrel_pkg::word_t   a,
    input  barrel_pkg::pc_t     d,
    input  logic                io_ready,
    thread_pc_if.pc_unit        threads,
    output barrel_pkg::pc_t     pc
);
    import barrel_pkg::*;

    logic jump;        // taken branch, two cycles late
    pc_t  d_q;         // branch target, same alignment
    logic io_ready_q;  // 0 means refetch

    branch_condition branch_condition_inst (
        .clock (clock),
        .rst_n (rst_n),
        .op    (op),
        .a     (a),
        .jump  (jump)
    );

    // ------------------------------------------------------------
    // align D and io_ready with the jump decision
    // ------------------------------------------------------------
    delay_line #(
        .payload_t   (pc_t),
        .DEPTH       (2),
        .RESET_VALUE (pc_t'(0))
    ) d_delay (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_data  (d),
        .out_data (d_q)
    );

    delay_line #(
        .payload_t   (logic),
        .DEPTH       (2),
        .RESET_VALUE (1'b1)  // no stall out of reset
    ) io_ready_delay (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_data  (io_ready),
        .out_data (io_ready_q)
    );

    // ------------------------------------------------------------
    // fetch address and write-back
    // ------------------------------------------------------------
    // the store holds the address after the last fetch, so a
    // stall steps back by one to fetch the same word again
    always_comb begin
        if (jump) begin
            pc = d_q;
        end else begin
            pc = threads.read_data - pc_t'(!io_ready_q);
        end
    end

    assign threads.write_data = pc + pc_t'(io_ready_q);  // wraps at PC width

endmodule

//--- src/thread_pc_store.sv
`timescale 1ns/1ps
`include "barrel_macros.svh"

module thread_pc_store (
    input  logic       clock,
    input  logic       rst_n,
    thread_pc_if.store threads
);
    import barrel_pkg::*;

    pc_t next_pc [`BC_THREAD_COUNT];  // one entry per thread
    pc_t read_q;

    // ------------------------------------------------------------
    // one write and one registered read every cycle
    // ------------------------------------------------------------
    // write_addr and read_addr are neighbouring threads, so the
    // two ports never touch the same entry in a cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `BC_THREAD_COUNT; i++) begin
                next_pc[i] <= '0;
            end
            read_q <= '0;  // thread 0 starts at pc 0
        end else begin
            next_pc[threads.write_addr] <= threads.write_data;
            read_q <= next_pc[threads.read_addr];
        end
    end

    assign threads.read_data = read_q;

endmodule

//--- src/thread_sequencer.sv
`timescale 1ns/1ps
`include "barrel_macros.svh"

module thread_sequencer (
    input  logic                clock,
    input  logic                rst_n,
    thread_pc_if.sequencer      threads,
    output barrel_pkg::thread_t thread
);
    import barrel_pkg::*;

    thread_t current_thread;
    thread_t next_thread;

    // compare against the last thread rather than subtract
    always_comb begin
        if (current_thread == thread_t'(`BC_THREAD_COUNT - 1)) begin
            next_thread = '0;  // wrap round
        end else begin
            next_thread = current_thread + thread_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            current_thread <= '0;
        end else begin
            current_thread <= next_thread;  // one thread per cycle
        end
    end

    assign threads.write_addr = current_thread;
    assign threads.read_addr  = next_thread;  // prefetch for next turn
    assign thread             = current_thread;

endmodule

//--- src/branch_condition.sv
`timescale 1ns/1ps

module branch_condition (
    input  logic                clock,
    input  logic                rst_n,
    input  barrel_pkg::opcode_t op,
    input  barrel_pkg::word_t   a,
    output logic                jump
);
    import barrel_pkg::*;

    opcode_t op_q;        // op lined up with the flags
    logic    a_zero;
    logic    a_positive;
    logic    jump_next;

    delay_line #(
        .payload_t   (opcode_t),
        .DEPTH       (1),
        .RESET_VALUE (opcode_t'(0))
    ) op_delay (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_data  (op),
        .out_data (op_q)
    );

    // ------------------------------------------------------------
    // accumulator flags, one cycle after A
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            a_zero     <= 1'b0;
            a_positive <= 1'b0;
        end else begin
            a_zero     <= (a == '0);
            a_positive <= ~a[$bits(word_t)-1];  // sign bit clear
        end
    end

    // ------------------------------------------------------------
    // branch table
    // ------------------------------------------------------------
    always_comb begin
        case (op_q)
            op_jmp:  jump_next = 1'b1;
            op_jze:  jump_next = a_zero;
            op_jnz:  jump_next = ~a_zero;
            op_jpo:  jump_next = a_positive;
            op_jne:  jump_next = ~a_positive;
            default: jump_next = 1'b0;  // not a branch
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            jump <= 1'b0;
        end else begin
            jump <= jump_next;
        end
    end

endmodule

//--- src/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
    parameter type      payload_t   = logic,
    parameter int       DEPTH       = 1,
    parameter payload_t RESET_VALUE = payload_t'(0)
) (
    input  logic     clock,
    input  logic     rst_n,
    input  payload_t in_data,
    output payload_t out_data
);

    payload_t stages [DEPTH];  // stage 0 takes the input

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= RESET_VALUE;
            end
        end else begin
            stages[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];  // shift one stage on
            end
        end
    end

    assign out_data = stages[DEPTH-1];

endmodule

//--- src/thread_pc_if.sv
`timescale 1ns/1ps

interface thread_pc_if;
    import barrel_pkg::*;

    thread_t write_addr;  // thread retiring this cycle
    thread_t read_addr;   // thread issuing next cycle
    pc_t     write_data;  // next-PC to keep for write_addr
    pc_t     read_data;   // stored next-PC of the active thread

    modport sequencer (
        output write_addr,
        output read_addr
    );

    modport store (
        input  write_addr,
        input  read_addr,
        input  write_data,
        output read_data
    );

    modport pc_unit (
        input  read_data,
        output write_data
    );
endinterface

//--- src/barrel_pkg.sv
`include "barrel_macros.svh"

package barrel_pkg;

    // ------------------------------------------------------------
    // instruction opcodes seen by the PC controller
    // ------------------------------------------------------------
    // codes outside this list are ordinary fall-through instructions
    typedef enum logic [`BC_OPCODE_WIDTH-1:0] {
        op_jmp = 8,   // unconditional
        op_jze = 9,   // A == 0
        op_jnz = 10,  // A != 0
        op_jpo = 11,  // A sign bit clear
        op_jne = 12   // A sign bit set
    } opcode_t;

    // ------------------------------------------------------------
    // data and address types
    // ------------------------------------------------------------
    typedef logic [`BC_A_WORD_WIDTH-1:0] word_t;       // accumulator
    typedef logic [`BC_PC_WIDTH-1:0] pc_t;             // program counter
    typedef logic [`BC_THREAD_ADDR_WIDTH-1:0] thread_t;  // thread number

endpackage

//--- include/barrel_macros.svh
`ifndef BARREL_MACROS_SVH
`define BARREL_MACROS_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define BC_OPCODE_WIDTH 4       // opcode field
`define BC_A_WORD_WIDTH 16      // accumulator word
`define BC_PC_WIDTH 10          // fetch address

// ------------------------------------------------------------
// thread rotation
// ------------------------------------------------------------
`define BC_THREAD_COUNT 8       // threads in the barrel
`define BC_THREAD_ADDR_WIDTH 3  // bits to number them

// cycles from op, A, D and io_ready to pc
`define BC_BRANCH_LATENCY 2

`endif
